// ==== verilog/soc_periph_pkg.sv ====
////////////////////
// soc peripheral package
// address map, register offsets, event ids and APB request/response types
////////////////////
package soc_periph_pkg;

    ////////////////////
    // apb bus
    ////////////////////
    localparam int APB_ADDR_W = 32;
    localparam int APB_DATA_W = 32;
    localparam int REG_OFFS_W = 8;      // register offset bits inside a slave

    // slave select field paddr[15:12]
    localparam int SLAVE_SEL_LSB = 12;
    localparam int SLAVE_SEL_W   = 4;
    localparam int NB_SLAVES     = 3;
    localparam int SLV_IDX_W     = $clog2(NB_SLAVES);

    localparam int SLV_GPIO  = 0;
    localparam int SLV_TIMER = 1;
    localparam int SLV_EVENT = 2;

    typedef struct packed {
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
        logic                  pwrite;
        logic                  psel;
        logic                  penable;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    ////////////////////
    // register offsets
    ////////////////////
    localparam int GPIO_W = 32;
    localparam logic [REG_OFFS_W-1:0] GPIO_DIR       = 8'h00;
    localparam logic [REG_OFFS_W-1:0] GPIO_IN        = 8'h04;  // read only
    localparam logic [REG_OFFS_W-1:0] GPIO_OUT       = 8'h08;
    localparam logic [REG_OFFS_W-1:0] GPIO_INTEN     = 8'h0C;
    localparam logic [REG_OFFS_W-1:0] GPIO_INTSTATUS = 8'h10;  // clear on read

    localparam logic [REG_OFFS_W-1:0] TIMER_CFG = 8'h00;       // bit 0 enable
    localparam logic [REG_OFFS_W-1:0] TIMER_CNT = 8'h04;
    localparam logic [REG_OFFS_W-1:0] TIMER_CMP = 8'h08;

    localparam logic [REG_OFFS_W-1:0] EVT_TRIG = 8'h00;        // write only
    localparam logic [REG_OFFS_W-1:0] EVT_MASK = 8'h04;        // bit 0 gpio, bit 1 timer
    localparam logic [REG_OFFS_W-1:0] EVT_ERR  = 8'h08;        // sticky overflow

    ////////////////////
    // events
    ////////////////////
    localparam int EVNT_WIDTH     = 8;
    localparam int EVT_FIFO_DEPTH = 4;
    localparam int EVT_PTR_W      = $clog2(EVT_FIFO_DEPTH);

    localparam logic [EVNT_WIDTH-1:0] EVT_ID_GPIO  = 8'd42;
    localparam logic [EVNT_WIDTH-1:0] EVT_ID_TIMER = 8'd10;

    // fc event word bit positions
    localparam int FC_EVT_W    = 32;
    localparam int FC_DMA_EVT  = 8;
    localparam int FC_DMA_IRQ  = 9;
    localparam int FC_TIMER    = 10;
    localparam int FC_PF_EVT   = 12;
    localparam int FC_REF_EDGE = 14;
    localparam int FC_GPIO     = 15;
    localparam int FC_ERR      = 29;

endpackage

// ==== verilog/periph_bus_decoder.sv ====
////////////////////
// peripheral bus decoder
// routes one APB request to a slave, answers unmapped indices with an error
////////////////////
`timescale 1ns/1ps

module periph_bus_decoder import soc_periph_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  apb_req_t                  req_i,
    input  apb_rsp_t [NB_SLAVES-1:0]  slv_rsp_i,
    output apb_req_t [NB_SLAVES-1:0]  slv_req_o,
    output apb_rsp_t                  rsp_o
);

    logic [SLAVE_SEL_W-1:0] sel;
    logic                   mapped;
    logic [NB_SLAVES-1:0]   psel_vec;

    assign sel    = req_i.paddr[SLAVE_SEL_LSB +: SLAVE_SEL_W];
    assign mapped = (sel < SLAVE_SEL_W'(NB_SLAVES));

    // same request to every slave, psel only where the index matches
    always_comb begin
        for (int i = 0; i < NB_SLAVES; i++) begin
            psel_vec[i]       = req_i.psel && (sel == SLAVE_SEL_W'(i));
            slv_req_o[i]      = req_i;
            slv_req_o[i].psel = psel_vec[i];
        end
    end

    ////////////////////
    // response mux
    ////////////////////
    always_comb begin
        if (mapped) begin
            rsp_o = slv_rsp_i[sel[SLV_IDX_W-1:0]];
        end else begin
            rsp_o.prdata  = '0;    // nobody home
            rsp_o.pready  = 1'b1;
            rsp_o.pslverr = 1'b1;
        end
    end

    // one slave at a time on the fan-out
    a_psel_onehot: assert property (
        @(posedge clk_i) disable iff (rst_i) $onehot0(psel_vec)
    );

endmodule

// ==== verilog/gpio_unit.sv ====
////////////////////
// gpio unit
// direction/output registers, pin synchronizer, rising edge interrupt
////////////////////
`timescale 1ns/1ps

module gpio_unit import soc_periph_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,
    input  apb_req_t          req_i,
    input  logic [GPIO_W-1:0] gpio_in_i,
    output apb_rsp_t          rsp_o,
    output logic [GPIO_W-1:0] gpio_out_o,
    output logic [GPIO_W-1:0] gpio_dir_o,
    output logic              gpio_evt_o
);

    logic [REG_OFFS_W-1:0] offs;
    logic                  wr_en;
    logic                  rd_status;

    logic [GPIO_W-1:0] dir_q;
    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] inten_q;
    logic [GPIO_W-1:0] status_q;
    logic [GPIO_W-1:0] sync0_q;
    logic [GPIO_W-1:0] sync1_q;
    logic [GPIO_W-1:0] prev_q;
    logic [GPIO_W-1:0] rise;
    logic              evt_q;

    assign offs      = req_i.paddr[REG_OFFS_W-1:0];
    assign wr_en     = req_i.psel & req_i.penable & req_i.pwrite;
    assign rd_status = req_i.psel & req_i.penable & ~req_i.pwrite & (offs == GPIO_INTSTATUS);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dir_q   <= '0;
            out_q   <= '0;
            inten_q <= '0;
        end else if (wr_en) begin
            case (offs)
                GPIO_DIR:   dir_q   <= req_i.pwdata[GPIO_W-1:0];
                GPIO_OUT:   out_q   <= req_i.pwdata[GPIO_W-1:0];
                GPIO_INTEN: inten_q <= req_i.pwdata[GPIO_W-1:0];
                default: ;
            endcase
        end
    end

    ////////////////////
    // pins and edges
    ////////////////////
    assign rise = sync1_q & ~prev_q & inten_q;   // enabled rising pins

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sync0_q  <= '0;
            sync1_q  <= '0;
            prev_q   <= '0;
            status_q <= '0;
            evt_q    <= 1'b0;
        end else begin
            sync0_q  <= gpio_in_i;
            sync1_q  <= sync0_q;
            prev_q   <= sync1_q;
            evt_q    <= |rise;
            // a fresh edge wins over the read clear
            status_q <= (rd_status ? '0 : status_q) | rise;
        end
    end

    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b0;
        case (offs)
            GPIO_DIR:       rsp_o.prdata = APB_DATA_W'(dir_q);
            GPIO_IN:        rsp_o.prdata = APB_DATA_W'(sync1_q);
            GPIO_OUT:       rsp_o.prdata = APB_DATA_W'(out_q);
            GPIO_INTEN:     rsp_o.prdata = APB_DATA_W'(inten_q);
            GPIO_INTSTATUS: rsp_o.prdata = APB_DATA_W'(status_q);
            default:        rsp_o.prdata = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;
    assign gpio_evt_o = evt_q;

endmodule

// ==== verilog/timer_unit.sv ====
////////////////////
// timer unit
// free running compare timer, one cycle event on match
////////////////////
`timescale 1ns/1ps

module timer_unit import soc_periph_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  apb_req_t req_i,
    output apb_rsp_t rsp_o,
    output logic     timer_evt_o
);

    logic [REG_OFFS_W-1:0] offs;
    logic                  wr_en;
    logic                  cnt_wr;
    logic                  hit;

    logic                  en_q;
    logic [APB_DATA_W-1:0] cnt_q;
    logic [APB_DATA_W-1:0] cmp_q;

    assign offs   = req_i.paddr[REG_OFFS_W-1:0];
    assign wr_en  = req_i.psel & req_i.penable & req_i.pwrite;
    assign cnt_wr = wr_en & (offs == TIMER_CNT);
    assign hit    = en_q && (cnt_q == cmp_q);

    ////////////////////
    // config and counter
    ////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            en_q  <= 1'b0;
            cnt_q <= '0;
            cmp_q <= '0;
        end else begin
            if (wr_en && offs == TIMER_CFG) en_q <= req_i.pwdata[0];
            if (wr_en && offs == TIMER_CMP) cmp_q <= req_i.pwdata;

            if (cnt_wr) begin
                cnt_q <= req_i.pwdata;    // sw write beats the increment
            end else if (hit) begin
                cnt_q <= '0;
            end else if (en_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = 1'b0;
        case (offs)
            TIMER_CFG: rsp_o.prdata = APB_DATA_W'(en_q);
            TIMER_CNT: rsp_o.prdata = cnt_q;
            TIMER_CMP: rsp_o.prdata = cmp_q;
            default:   rsp_o.prdata = '0;
        endcase
    end

    assign timer_evt_o = hit;

    // stopped timer stays quiet
    a_evt_enabled: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !en_q && !(wr_en && offs == TIMER_CFG && req_i.pwdata[0]) |=> !timer_evt_o
    );

endmodule

// ==== verilog/event_unit.sv ====
////////////////////
// event unit
// fc event word, ref clock edge detect, event queue towards the fabric controller
////////////////////
`timescale 1ns/1ps

module event_unit import soc_periph_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  apb_req_t              req_i,
    input  logic                  slow_clk_i,
    input  logic                  gpio_evt_i,
    input  logic                  timer_evt_i,
    input  logic                  dma_pe_evt_i,
    input  logic                  dma_pe_irq_i,
    input  logic                  pf_evt_i,
    input  logic                  fc_event_ready_i,
    output apb_rsp_t              rsp_o,
    output logic [FC_EVT_W-1:0]   fc_events_o,
    output logic                  fc_event_valid_o,
    output logic [EVNT_WIDTH-1:0] fc_event_data_o
);

    logic [REG_OFFS_W-1:0] offs;
    logic                  wr_en;
    logic                  rd_err;
    logic                  sw_trig;
    logic                  gpio_req;
    logic                  timer_req;
    logic                  push;
    logic                  pop;
    logic                  full;
    logic                  ovf;
    logic [EVNT_WIDTH-1:0] push_data;

    logic [1:0]            ref_sync_q;
    logic                  ref_prev_q;
    logic                  ref_edge;
    logic [1:0]            mask_q;
    logic                  err_q;

    logic [EVNT_WIDTH-1:0] fifo_mem [EVT_FIFO_DEPTH];
    logic [EVT_PTR_W-1:0]  wr_ptr_q;
    logic [EVT_PTR_W-1:0]  rd_ptr_q;
    logic [EVT_PTR_W:0]    count_q;

    assign offs      = req_i.paddr[REG_OFFS_W-1:0];
    assign wr_en     = req_i.psel & req_i.penable & req_i.pwrite;
    assign rd_err    = req_i.psel & req_i.penable & ~req_i.pwrite & (offs == EVT_ERR);
    assign sw_trig   = wr_en & (offs == EVT_TRIG);
    assign gpio_req  = gpio_evt_i & mask_q[0];
    assign timer_req = timer_evt_i & mask_q[1];
    assign full      = (count_q == (EVT_PTR_W+1)'(EVT_FIFO_DEPTH));
    assign pop       = fc_event_valid_o & fc_event_ready_i;

    ////////////////////
    // push arbitration
    ////////////////////
    always_comb begin
        push      = 1'b0;
        push_data = '0;
        ovf       = 1'b0;
        if (sw_trig) begin
            push      = !full;
            push_data = req_i.pwdata[EVNT_WIDTH-1:0];
            ovf       = gpio_req | timer_req;    // peripherals lose this slot
        end else if (gpio_req) begin
            push      = !full;
            push_data = EVT_ID_GPIO;
            ovf       = full | timer_req;
        end else if (timer_req) begin
            push      = !full;
            push_data = EVT_ID_TIMER;
            ovf       = full;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) fifo_mem[wr_ptr_q] <= push_data;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            count_q    <= '0;
            mask_q     <= '0;
            err_q      <= 1'b0;
            ref_sync_q <= '0;
            ref_prev_q <= 1'b0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (EVT_PTR_W+1)'(push) - (EVT_PTR_W+1)'(pop);
            if (wr_en && offs == EVT_MASK) mask_q <= req_i.pwdata[1:0];
            err_q      <= (rd_err ? 1'b0 : err_q) | ovf;
            ref_sync_q <= {ref_sync_q[0], slow_clk_i};
            ref_prev_q <= ref_sync_q[1];
        end
    end

    assign ref_edge         = ref_sync_q[1] ^ ref_prev_q;   // both edges
    assign fc_event_valid_o = (count_q != '0);
    assign fc_event_data_o  = fifo_mem[rd_ptr_q];

    always_comb begin
        rsp_o.pready  = 1'b1;
        rsp_o.pslverr = sw_trig & full;   // trigger dropped
        case (offs)
            EVT_MASK: rsp_o.prdata = APB_DATA_W'(mask_q);
            EVT_ERR:  rsp_o.prdata = APB_DATA_W'(err_q);
            default:  rsp_o.prdata = '0;
        endcase
    end

    ////////////////////
    // fc event word
    ////////////////////
    always_comb begin
        fc_events_o              = '0;
        fc_events_o[FC_DMA_EVT]  = dma_pe_evt_i;
        fc_events_o[FC_DMA_IRQ]  = dma_pe_irq_i;
        fc_events_o[FC_TIMER]    = timer_evt_i;
        fc_events_o[FC_PF_EVT]   = pf_evt_i;
        fc_events_o[FC_REF_EDGE] = ref_edge;
        fc_events_o[FC_GPIO]     = gpio_evt_i;
        fc_events_o[FC_ERR]      = err_q;
    end

    // a full queue takes no new entry
    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (rst_i) full |=> $stable(wr_ptr_q)
    );

    // entry holds while the receiver stalls
    a_hold_stable: assert property (
        @(posedge clk_i) disable iff (rst_i)
        fc_event_valid_o && !fc_event_ready_i |=> fc_event_valid_o && $stable(fc_event_data_o)
    );

endmodule

// ==== verilog/soc_peripherals.sv ====
////////////////////
// soc peripherals top
// APB decoder with gpio, timer and event units
////////////////////
`timescale 1ns/1ps

module soc_peripherals import soc_periph_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  apb_req_t              apb_req_i,
    input  logic [GPIO_W-1:0]     gpio_in_i,
    input  logic                  slow_clk_i,
    input  logic                  dma_pe_evt_i,
    input  logic                  dma_pe_irq_i,
    input  logic                  pf_evt_i,
    input  logic                  fc_event_ready_i,
    output apb_rsp_t              apb_rsp_o,
    output logic [GPIO_W-1:0]     gpio_out_o,
    output logic [GPIO_W-1:0]     gpio_dir_o,
    output logic [FC_EVT_W-1:0]   fc_events_o,
    output logic                  fc_event_valid_o,
    output logic [EVNT_WIDTH-1:0] fc_event_data_o
);

    apb_req_t [NB_SLAVES-1:0] slv_req;
    apb_rsp_t [NB_SLAVES-1:0] slv_rsp;
    logic                     gpio_evt;
    logic                     timer_evt;

    ////////////////////
    // apb fan-out
    ////////////////////
    periph_bus_decoder periph_bus_i (
        .clk_i     ( clk_i     ),
        .rst_i     ( rst_i     ),
        .req_i     ( apb_req_i ),
        .slv_rsp_i ( slv_rsp   ),
        .slv_req_o ( slv_req   ),
        .rsp_o     ( apb_rsp_o )
    );

    gpio_unit gpio_i (
        .clk_i      ( clk_i             ),
        .rst_i      ( rst_i             ),
        .req_i      ( slv_req[SLV_GPIO] ),
        .gpio_in_i  ( gpio_in_i         ),
        .rsp_o      ( slv_rsp[SLV_GPIO] ),
        .gpio_out_o ( gpio_out_o        ),
        .gpio_dir_o ( gpio_dir_o        ),
        .gpio_evt_o ( gpio_evt          )
    );

    timer_unit timer_i (
        .clk_i       ( clk_i              ),
        .rst_i       ( rst_i              ),
        .req_i       ( slv_req[SLV_TIMER] ),
        .rsp_o       ( slv_rsp[SLV_TIMER] ),
        .timer_evt_o ( timer_evt          )
    );

    ////////////////////
    // events to fc
    ////////////////////
    event_unit event_i (
        .clk_i            ( clk_i              ),
        .rst_i            ( rst_i              ),
        .req_i            ( slv_req[SLV_EVENT] ),
        .slow_clk_i       ( slow_clk_i         ),
        .gpio_evt_i       ( gpio_evt           ),
        .timer_evt_i      ( timer_evt          ),
        .dma_pe_evt_i     ( dma_pe_evt_i       ),
        .dma_pe_irq_i     ( dma_pe_irq_i       ),
        .pf_evt_i         ( pf_evt_i           ),
        .fc_event_ready_i ( fc_event_ready_i   ),
        .rsp_o            ( slv_rsp[SLV_EVENT] ),
        .fc_events_o      ( fc_events_o        ),
        .fc_event_valid_o ( fc_event_valid_o   ),
        .fc_event_data_o  ( fc_event_data_o    )
    );

endmodule

// ==== sim/tb_soc_peripherals.sv ====
////////////////////
// soc peripherals testbench
// random APB traffic, pin and event stimulus checked against a local model
////////////////////
`timescale 1ns/1ps

module tb_soc_peripherals import soc_periph_pkg::*; ();

    localparam int MAX_CYCLES = 20000;   // well above the summed test length

    logic                  clk_i;
    logic                  rst_i;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic [GPIO_W-1:0]     gpio_in;
    logic [GPIO_W-1:0]     gpio_out;
    logic [GPIO_W-1:0]     gpio_dir;
    logic                  slow_clk;
    logic                  dma_pe_evt;
    logic                  dma_pe_irq;
    logic                  pf_evt;
    logic                  fc_event_ready;
    logic [FC_EVT_W-1:0]   fc_events;
    logic                  fc_event_valid;
    logic [EVNT_WIDTH-1:0] fc_event_data;

    logic [31:0]           lfsr_q = 32'h2e91;
    logic                  ready_rand;       // ready follows the lfsr each cycle
    logic [EVNT_WIDTH-1:0] exp_q[$];         // expected event queue
    int                    fill_seen;        // model fill during the last access cycle
    int                    errors = 0;
    int                    cycle_cnt = 0;
    logic                  stall_q = 1'b0;
    logic [EVNT_WIDTH-1:0] held_data;
    logic [EVNT_WIDTH-1:0] head;

    soc_peripherals dut_i (
        .clk_i            ( clk_i          ),
        .rst_i            ( rst_i          ),
        .apb_req_i        ( apb_req        ),
        .gpio_in_i        ( gpio_in        ),
        .slow_clk_i       ( slow_clk       ),
        .dma_pe_evt_i     ( dma_pe_evt     ),
        .dma_pe_irq_i     ( dma_pe_irq     ),
        .pf_evt_i         ( pf_evt         ),
        .fc_event_ready_i ( fc_event_ready ),
        .apb_rsp_o        ( apb_rsp        ),
        .gpio_out_o       ( gpio_out       ),
        .gpio_dir_o       ( gpio_dir       ),
        .fc_events_o      ( fc_events      ),
        .fc_event_valid_o ( fc_event_valid ),
        .fc_event_data_o  ( fc_event_data  )
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    ////////////////////
    // helpers
    ////////////////////
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [31:0] reg_addr(input int slv, input logic [7:0] offs);
        return (32'(slv) << SLAVE_SEL_LSB) | 32'(offs);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    // inputs change 2 ns after the edge
    task automatic next_cycle();
        logic [31:0] r;
        @(posedge clk_i);
        #2;
        if (ready_rand) begin
            rand_bits(2, r);
            fc_event_ready = (r[1:0] == 2'b11);   // mostly stalled
        end
    endtask

    task automatic apb_access(input logic [31:0] addr, input logic [31:0] data,
                              input logic wr, output logic [31:0] rdata, output logic err);
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        apb_req.pwrite  = wr;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        next_cycle();
        apb_req.penable = 1'b1;
        #1;
        rdata     = apb_rsp.prdata;
        err       = apb_rsp.pslverr;
        fill_seen = exp_q.size();
        check_eq("apb pready", 32'd1, 32'(apb_rsp.pready));
        next_cycle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused_rd;
        apb_access(addr, data, 1'b1, unused_rd, err);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(addr, 32'd0, 1'b0, rdata, err);
    endtask

    task automatic drain_queue(input string name);
        int wait_cnt;
        wait_cnt       = 0;
        ready_rand     = 1'b0;
        fc_event_ready = 1'b1;
        while (exp_q.size() != 0 && wait_cnt < 32) begin
            next_cycle();
            wait_cnt++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: event queue did not drain, %0d left", name, exp_q.size());
            errors++;
        end
        check_eq({name, " valid after drain"}, 32'd0, 32'(fc_event_valid));
    endtask

    ////////////////////
    // queue monitor and timeout
    ////////////////////
    // ready and queue outputs have settled by mid cycle
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (stall_q) begin
                check_eq("event_queue hold valid", 32'd1, 32'(fc_event_valid));
                check_eq("event_queue hold data", 32'(held_data), 32'(fc_event_data));
            end
            if (fc_event_valid && fc_event_ready) begin
                if (exp_q.size() == 0) begin
                    $display("event queue handed out id %h with none expected", fc_event_data);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    check_eq("event_queue order", 32'(head), 32'(fc_event_data));
                end
            end
            stall_q   = fc_event_valid && !fc_event_ready;
            held_data = fc_event_data;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            errors++;
            $display("errors: %0d", errors);
            $display("=== FAIL ===");
            $finish;
        end
    end

    ////////////////////
    // tests
    ////////////////////
    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic [31:0] o;
        logic [31:0] pins;
        logic [31:0] mask;
        logic [31:0] rd;
        logic [31:0] exp_word;
        logic        err;
        int          gap;
        int          cmp;
        int          pulses;
        int          full_hits;

        apb_req        = '0;
        gpio_in        = '0;
        slow_clk       = 1'b0;
        dma_pe_evt     = 1'b0;
        dma_pe_irq     = 1'b0;
        pf_evt         = 1'b0;
        fc_event_ready = 1'b0;
        ready_rand     = 1'b0;
        rst_i          = 1'b1;
        repeat (4) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        check_eq("reset gpio_out", 32'd0, gpio_out);
        check_eq("reset gpio_dir", 32'd0, gpio_dir);
        check_eq("reset fc_event_valid", 32'd0, 32'(fc_event_valid));
        check_eq("reset fc_events", 32'd0, fc_events);

        // gpio registers
        for (int i = 0; i < 16; i++) begin
            rand_bits(32, d);
            rand_bits(32, o);
            apb_write(reg_addr(SLV_GPIO, GPIO_DIR), d, err);
            apb_write(reg_addr(SLV_GPIO, GPIO_OUT), o, err);
            apb_read(reg_addr(SLV_GPIO, GPIO_DIR), rd, err);
            check_eq("gpio_regs dir readback", d, rd);
            apb_read(reg_addr(SLV_GPIO, GPIO_OUT), rd, err);
            check_eq("gpio_regs out readback", o, rd);
            check_eq("gpio_regs gpio_dir_o", d, gpio_dir);
            check_eq("gpio_regs gpio_out_o", o, gpio_out);
            rand_bits(32, pins);
            gpio_in = pins;
            next_cycle();
            next_cycle();                  // two synchronizer stages
            apb_read(reg_addr(SLV_GPIO, GPIO_IN), rd, err);
            check_eq("gpio_regs in", pins, rd);
        end

        // gpio interrupt
        for (int i = 0; i < 32; i++) begin
            gpio_in = '0;
            repeat (4) next_cycle();
            rand_bits(32, mask);
            apb_write(reg_addr(SLV_GPIO, GPIO_INTEN), mask, err);
            rand_bits(32, r);
            rand_bits(32, d);
            rand_bits(32, o);
            pins    = r & d & o;            // sparse rises
            gpio_in = pins;
            for (int c = 1; c <= 4; c++) begin
                next_cycle();
                if (c == 3) check_eq("gpio_irq pulse", 32'(|(pins & mask)), 32'(fc_events[FC_GPIO]));
                else check_eq("gpio_irq no pulse", 32'd0, 32'(fc_events[FC_GPIO]));
            end
            apb_read(reg_addr(SLV_GPIO, GPIO_INTSTATUS), rd, err);
            check_eq("gpio_irq status", pins & mask, rd);
            apb_read(reg_addr(SLV_GPIO, GPIO_INTSTATUS), rd, err);
            check_eq("gpio_irq status cleared", 32'd0, rd);
        end
        gpio_in = '0;

        // timer period
        for (int i = 0; i < 8; i++) begin
            rand_bits(5, r);
            cmp = 2 + int'(r % 29);
            apb_write(reg_addr(SLV_TIMER, TIMER_CMP), 32'(cmp), err);
            apb_write(reg_addr(SLV_TIMER, TIMER_CNT), 32'd0, err);
            apb_write(reg_addr(SLV_TIMER, TIMER_CFG), 32'd1, err);
            gap = 0;
            do begin
                next_cycle();
                gap++;
            end while (!fc_events[FC_TIMER] && gap < 64);
            if (!fc_events[FC_TIMER]) begin
                $display("timer: no event after enable with compare %0d", cmp);
                errors++;
            end
            for (int k = 0; k < 3; k++) begin
                gap = 0;
                do begin
                    next_cycle();
                    gap++;
                end while (!fc_events[FC_TIMER] && gap < 64);
                check_eq("timer period", 32'(cmp + 1), 32'(gap));
            end
            apb_write(reg_addr(SLV_TIMER, TIMER_CFG), 32'd0, err);
            pulses = 0;
            repeat (2 * (cmp + 1)) begin
                next_cycle();
                if (fc_events[FC_TIMER]) pulses++;
            end
            check_eq("timer disabled pulses", 32'd0, 32'(pulses));
        end

        // event queue under back-pressure
        full_hits  = 0;
        ready_rand = 1'b1;
        for (int i = 0; i < 400; i++) begin
            rand_bits(8, d);
            apb_write(reg_addr(SLV_EVENT, EVT_TRIG), d, err);
            if (fill_seen == EVT_FIFO_DEPTH) begin
                check_eq("event_queue full pslverr", 32'd1, 32'(err));
                full_hits++;
            end else begin
                check_eq("event_queue pslverr", 32'd0, 32'(err));
                exp_q.push_back(d[EVNT_WIDTH-1:0]);
            end
            rand_bits(1, r);
            if (r[0]) next_cycle();
        end
        if (full_hits == 0) begin
            $display("event_queue: the queue never filled up");
            errors++;
        end
        drain_queue("event_queue");

        // peripheral events and overflow with the receiver stalled
        fc_event_ready = 1'b0;
        apb_write(reg_addr(SLV_GPIO, GPIO_INTEN), 32'hffff_ffff, err);
        apb_write(reg_addr(SLV_EVENT, EVT_MASK), 32'd3, err);
        apb_write(reg_addr(SLV_TIMER, TIMER_CMP), 32'd5, err);
        apb_write(reg_addr(SLV_TIMER, TIMER_CNT), 32'd0, err);
        gpio_in = 32'd1;
        repeat (5) next_cycle();
        exp_q.push_back(EVT_ID_GPIO);
        apb_write(reg_addr(SLV_TIMER, TIMER_CFG), 32'd1, err);
        repeat (40) next_cycle();          // several periods so the last ones overflow
        apb_write(reg_addr(SLV_TIMER, TIMER_CFG), 32'd0, err);
        repeat (3) exp_q.push_back(EVT_ID_TIMER);
        check_eq("periph_evt err bit", 32'd1, 32'(fc_events[FC_ERR]));
        check_eq("periph_evt head", 32'(EVT_ID_GPIO), 32'(fc_event_data));
        apb_write(reg_addr(SLV_EVENT, EVT_TRIG), 32'h77, err);
        check_eq("periph_evt full trigger pslverr", 32'd1, 32'(err));
        apb_read(reg_addr(SLV_EVENT, EVT_ERR), rd, err);
        check_eq("periph_evt err read", 32'd1, rd);
        apb_read(reg_addr(SLV_EVENT, EVT_ERR), rd, err);
        check_eq("periph_evt err cleared", 32'd0, rd);
        check_eq("periph_evt err bit cleared", 32'd0, 32'(fc_events[FC_ERR]));
        apb_write(reg_addr(SLV_EVENT, EVT_MASK), 32'd0, err);
        gpio_in = '0;
        drain_queue("periph_evt");

        // pass-through bits
        for (int i = 0; i < 32; i++) begin
            rand_bits(3, r);
            dma_pe_evt = r[0];
            dma_pe_irq = r[1];
            pf_evt     = r[2];
            #1;
            exp_word             = '0;
            exp_word[FC_DMA_EVT] = r[0];
            exp_word[FC_DMA_IRQ] = r[1];
            exp_word[FC_PF_EVT]  = r[2];
            check_eq("pass_through word", exp_word, fc_events);
            next_cycle();
        end
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;

        // reference clock edges in both directions
        for (int i = 0; i < 8; i++) begin
            slow_clk = ~slow_clk;
            pulses   = 0;
            repeat (5) begin
                next_cycle();
                if (fc_events[FC_REF_EDGE]) pulses++;
            end
            check_eq("ref_edge pulses", 32'd1, 32'(pulses));
        end

        // unmapped slave index
        apb_read(reg_addr(5, 8'h00), rd, err);
        check_eq("decode_err read pslverr", 32'd1, 32'(err));
        check_eq("decode_err read prdata", 32'd0, rd);
        apb_write(reg_addr(5, 8'h04), 32'hdead_beef, err);
        check_eq("decode_err write pslverr", 32'd1, 32'(err));

        repeat (2) next_cycle();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/soc_periph_pkg.sv
verilog/periph_bus_decoder.sv
verilog/gpio_unit.sv
verilog/timer_unit.sv
verilog/event_unit.sv
verilog/soc_peripherals.sv
sim/tb_soc_peripherals.sv

// ==== Makefile ====
# Verilator build and run for the SoC peripheral block

SIM = obj_dir/Vtb_soc_peripherals

all: run

$(SIM): build.f $(wildcard verilog/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_soc_peripherals -f build.f -o Vtb_soc_peripherals

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
